/* design/rv_core.sv */
`timescale 1ns/1ps

module rv_core
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  instr_t    imem_data_i,
    output word_t     imem_addr_o,
    output logic      wb_en_o,      // One pulse per committed write
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o
);

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;
    logic    stall;
    logic    redirect;
    word_t   target;

    //////////////////////////////
    // Stage chain
    //////////////////////////////

    rv_fetch rv_fetch_inst (
        .clk         (clk),
        .rst         (rst),
        .stall_i     (stall),
        .redirect_i  (redirect),
        .target_i    (target),
        .imem_data_i (imem_data_i),
        .imem_addr_o (imem_addr_o),
        .if_id_o     (if_id)
    );

    rv_decode rv_decode_inst (
        .clk      (clk),
        .rst      (rst),
        .if_id_i  (if_id),
        .flush_i  (redirect),   // Same pulse kills the decode slot
        .wb_i     (mem_wb),
        .stall_o  (stall),
        .id_ex_o  (id_ex)
    );

    rv_execute rv_execute_inst (
        .clk        (clk),
        .rst        (rst),
        .id_ex_i    (id_ex),
        .wb_i       (mem_wb),
        .redirect_o (redirect),
        .target_o   (target),
        .ex_mem_o   (ex_mem)
    );

    rv_memory rv_memory_inst (
        .clk      (clk),
        .rst      (rst),
        .ex_mem_i (ex_mem),
        .mem_wb_o (mem_wb)
    );

    // Commit view straight from MEM/WB
    assign wb_en_o   = mem_wb.reg_write;
    assign wb_rd_o   = mem_wb.rd;
    assign wb_data_o = mem_wb.data;

endmodule

/* design/rv_core_config.svh */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

//////////////////////////////
// Datapath
//////////////////////////////

// Data and address width
`define RV_XLEN 32

// Register index width, 32 integer registers
`define RV_REG_ADDR_W 5

//////////////////////////////
// Memory and reset
//////////////////////////////

// Data memory depth in words
`define RV_DMEM_WORDS 256

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* design/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_decode
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  if_id_t  if_id_i,
    input  logic    flush_i,    // Taken branch in execute
    input  mem_wb_t wb_i,       // Register file write port
    output logic    stall_o,
    output id_ex_t  id_ex_o
);

    instr_t    instr;
    reg_addr_t rs1_a, rs2_a, rd_a;
    funct3_t   f3;
    word_t     imm_i, imm_s, imm_b;
    word_t     rf [32];
    ctrl_t     ctrl_d;
    alu_op_e   alu_op_d;
    logic      alu_ok, rs1_used, rs2_used;
    id_ex_t    id_ex_d;

    assign instr = if_id_i.instr;
    assign rs1_a = instr[19:15];
    assign rs2_a = instr[24:20];
    assign rd_a  = instr[11:7];
    assign f3    = instr[14:12];

    assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};

    //////////////////////////////
    // Register file
    //////////////////////////////

    // x0 reads as zero, a write in the same cycle is passed through
    function automatic word_t rf_read(reg_addr_t addr);
        if (addr == '0)
            return '0;
        if (wb_i.reg_write && wb_i.rd == addr)
            return wb_i.data;
        return rf[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (wb_i.reg_write && wb_i.rd != '0)
            rf[wb_i.rd] <= wb_i.data;
    end

    //////////////////////////////
    // Decoder
    //////////////////////////////

    always_comb begin
        alu_ok   = 1'b1;
        alu_op_d = ALU_ADD;
        case (f3)
            F3_ADD_SUB: alu_op_d = (instr[6:0] == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
            F3_SLT:     alu_op_d = ALU_SLT;
            F3_XOR:     alu_op_d = ALU_XOR;
            F3_OR:      alu_op_d = ALU_OR;
            F3_AND:     alu_op_d = ALU_AND;
            default:    alu_ok   = 1'b0;  // Shifts and unsigned compare not supported
        endcase
    end

    always_comb begin
        ctrl_d   = CTRL_BUBBLE;
        rs1_used = 1'b1;
        rs2_used = 1'b0;
        id_ex_d.imm = imm_i;
        case (instr[6:0])
            OPC_OP: begin
                rs2_used         = 1'b1;
                ctrl_d.alu_op    = alu_op_d;
                ctrl_d.reg_write = alu_ok;
            end
            OPC_OP_IMM: begin
                ctrl_d.alu_op      = alu_op_d;
                ctrl_d.alu_src_imm = 1'b1;
                ctrl_d.reg_write   = alu_ok;
            end
            OPC_LOAD: begin
                ctrl_d.alu_src_imm = 1'b1;
                ctrl_d.mem_read    = (f3 == F3_WORD);
                ctrl_d.reg_write   = (f3 == F3_WORD);
                ctrl_d.mem_to_reg  = 1'b1;
            end
            OPC_STORE: begin
                rs2_used           = 1'b1;
                id_ex_d.imm        = imm_s;
                ctrl_d.alu_src_imm = 1'b1;
                ctrl_d.mem_write   = (f3 == F3_WORD);
            end
            OPC_BRANCH: begin
                rs2_used    = 1'b1;
                id_ex_d.imm = imm_b;
                if (f3 == F3_BEQ)
                    ctrl_d.br_kind = BR_BEQ;
                else if (f3 == F3_BNE)
                    ctrl_d.br_kind = BR_BNE;
            end
            default: rs1_used = 1'b0;  // Bubble or unsupported opcode
        endcase
        if (rd_a == '0)
            ctrl_d.reg_write = 1'b0;   // Writes to x0 are dropped here
        id_ex_d.pc      = if_id_i.pc;
        id_ex_d.rs1_val = rf_read(rs1_a);
        id_ex_d.rs2_val = rf_read(rs2_a);
        id_ex_d.rs1     = rs1_a;
        id_ex_d.rs2     = rs2_a;
        id_ex_d.rd      = rd_a;
        id_ex_d.ctrl    = ctrl_d;
    end

    // Load in execute feeding this instruction
    assign stall_o = id_ex_o.ctrl.mem_read && id_ex_o.rd != '0 &&
                     ((rs1_used && id_ex_o.rd == rs1_a) || (rs2_used && id_ex_o.rd == rs2_a));

    always_ff @(posedge clk) begin
        if (rst || flush_i || stall_o)
            id_ex_o.ctrl <= CTRL_BUBBLE;
        else
            id_ex_o <= id_ex_d;
    end

endmodule

/* design/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  id_ex_t  id_ex_i,
    input  mem_wb_t wb_i,       // MEM/WB forwarding source
    output logic    redirect_o,
    output word_t   target_o,
    output ex_mem_t ex_mem_o
);

    word_t rs1_fwd, rs2_fwd;
    word_t op_b;
    word_t alu_res;
    logic  ops_equal;

    //////////////////////////////
    // Forwarding
    //////////////////////////////

    // EX/MEM is newer than MEM/WB and is checked last
    function automatic word_t fwd_operand(reg_addr_t src, word_t id_val,
                                          ex_mem_t exm, mem_wb_t wb);
        word_t val;
        val = id_val;
        if (src != '0 && wb.reg_write && wb.rd == src)
            val = wb.data;
        if (src != '0 && exm.reg_write && exm.rd == src)
            val = exm.alu_res;  // Never a load, decode stalls for those
        return val;
    endfunction

    always_comb begin
        rs1_fwd = fwd_operand(id_ex_i.rs1, id_ex_i.rs1_val, ex_mem_o, wb_i);
        rs2_fwd = fwd_operand(id_ex_i.rs2, id_ex_i.rs2_val, ex_mem_o, wb_i);
    end

    //////////////////////////////
    // ALU and branch
    //////////////////////////////

    assign op_b = id_ex_i.ctrl.alu_src_imm ? id_ex_i.imm : rs2_fwd;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_SUB: alu_res = rs1_fwd - op_b;
            ALU_AND: alu_res = rs1_fwd & op_b;
            ALU_OR:  alu_res = rs1_fwd | op_b;
            ALU_XOR: alu_res = rs1_fwd ^ op_b;
            ALU_SLT: alu_res = word_t'($signed(rs1_fwd) < $signed(op_b));
            default: alu_res = rs1_fwd + op_b;   // ADD, also address generation
        endcase
    end

    assign ops_equal  = (rs1_fwd == rs2_fwd);
    assign redirect_o = (id_ex_i.ctrl.br_kind == BR_BEQ &&  ops_equal) ||
                        (id_ex_i.ctrl.br_kind == BR_BNE && !ops_equal);
    assign target_o   = id_ex_i.pc + id_ex_i.imm;

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem_o.mem_write  <= 1'b0;
            ex_mem_o.reg_write  <= 1'b0;
            ex_mem_o.mem_to_reg <= 1'b0;
        end else begin
            ex_mem_o.alu_res    <= alu_res;
            ex_mem_o.store_data <= rs2_fwd;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.mem_write  <= id_ex_i.ctrl.mem_write;
            ex_mem_o.reg_write  <= id_ex_i.ctrl.reg_write;
            ex_mem_o.mem_to_reg <= id_ex_i.ctrl.mem_to_reg;
        end
    end

endmodule

/* design/rv_fetch.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_fetch
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   stall_i,      // Load-use hold from decode
    input  logic   redirect_i,   // Taken branch from execute
    input  word_t  target_i,
    input  instr_t imem_data_i,
    output word_t  imem_addr_o,
    output if_id_t if_id_o
);

    word_t pc_q;

    assign imem_addr_o = pc_q;  // Instruction memory answers in the same cycle

    //////////////////////////////
    // PC and IF/ID register
    //////////////////////////////

    // Redirect has priority over stall
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q          <= `RV_RESET_PC;
            if_id_o.instr <= INSTR_BUBBLE;
        end else if (redirect_i) begin
            pc_q          <= target_i;
            if_id_o.instr <= INSTR_BUBBLE;  // Kill the word fetched this cycle
        end else if (!stall_i) begin
            pc_q          <= pc_q + word_t'(4);
            if_id_o.pc    <= pc_q;
            if_id_o.instr <= imem_data_i;
        end
    end

endmodule

/* design/rv_isa_pkg.sv */
`include "rv_core_config.svh"

package rv_isa_pkg;

    //////////////////////////////
    // Field types
    //////////////////////////////

    typedef logic [`RV_XLEN-1:0]       word_t;      // Data or address
    typedef logic [31:0]               instr_t;     // Raw instruction
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;  // Register index
    typedef logic [2:0]                funct3_t;

    //////////////////////////////
    // Opcodes and funct3 codes
    //////////////////////////////

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // Register-register ALU
        OPC_OP_IMM = 7'b0010011,  // Register-immediate ALU
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // ALU group, shared by OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLT     = 3'b010,
        F3_XOR     = 3'b100,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } alu_funct3_e;

    typedef enum logic [2:0] {
        F3_BEQ = 3'b000,
        F3_BNE = 3'b001
    } br_funct3_e;

    // Only word accesses are legal for LOAD and STORE
    localparam funct3_t F3_WORD = 3'b010;

    //////////////////////////////
    // Internal operation codes
    //////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT   // Signed compare, result 0 or 1
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE
    } br_kind_e;

endpackage

/* design/rv_memory.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_memory
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  ex_mem_t ex_mem_i,
    output mem_wb_t mem_wb_o
);

    localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

    word_t              dmem [`RV_DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;
    word_t              load_data;
    word_t              wb_data;

    //////////////////////////////
    // Data memory
    //////////////////////////////

    // Byte offset dropped, upper bits wrap around the array
    assign word_idx = ex_mem_i.alu_res[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (ex_mem_i.mem_write)
            dmem[word_idx] <= ex_mem_i.store_data;
    end

    assign load_data = dmem[word_idx];  // Combinational read

    //////////////////////////////
    // Write-back select and MEM/WB
    //////////////////////////////

    assign wb_data = ex_mem_i.mem_to_reg ? load_data : ex_mem_i.alu_res;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb_o.reg_write <= 1'b0;
        end else begin
            mem_wb_o.reg_write <= ex_mem_i.reg_write;
            mem_wb_o.rd        <= ex_mem_i.rd;
            mem_wb_o.data      <= wb_data;
        end
    end

endmodule

/* design/rv_pipe_pkg.sv */
package rv_pipe_pkg;

    import rv_isa_pkg::*;

    // Decoded control, cleared to zero for a bubble
    typedef struct packed {
        alu_op_e  alu_op;
        logic     alu_src_imm;  // Operand B from immediate
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        logic     mem_to_reg;   // Write back load data
        br_kind_e br_kind;
    } ctrl_t;

    localparam ctrl_t  CTRL_BUBBLE  = '0;
    localparam instr_t INSTR_BUBBLE = '0;  // Decodes to no operation

    //////////////////////////////
    // Stage registers
    //////////////////////////////

    typedef struct packed {
        word_t  pc;
        instr_t instr;
    } if_id_t;

    typedef struct packed {
        word_t     pc;
        word_t     rs1_val;
        word_t     rs2_val;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        ctrl_t     ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t     alu_res;     // Also the data address
        word_t     store_data;
        reg_addr_t rd;
        logic      mem_write;
        logic      reg_write;
        logic      mem_to_reg;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t rd;
        word_t     data;
    } mem_wb_t;

endpackage

/* rv_core.f */
+incdir+design
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_memory.sv
design/rv_core.sv
verification/rv_core_assertions.sv
verification/rv_core_tb.sv

/* verification/rv_core_assertions.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_core_assertions
    import rv_isa_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input word_t     imem_addr_i,
    input logic      wb_en_i,
    input reg_addr_t wb_rd_i
);

    int fail_count = 0;  // Failed port checks so far

    // First write needs four edges to reach MEM/WB
    wb_quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> (!wb_en_i) [*4])
        else begin
            fail_count++;
            $error("wb_en_o rose within four cycles of reset release");
        end

    wb_rd_nonzero: assert property (@(posedge clk) disable iff (rst) wb_en_i |-> wb_rd_i != '0)
        else begin
            fail_count++;
            $error("Write-back to x0 seen on the port");
        end

    imem_aligned: assert property (@(posedge clk) disable iff (rst) imem_addr_i[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("Fetch address %h is not word aligned", imem_addr_i);
        end

    reset_pc: assert property (@(posedge clk) $fell(rst) |-> imem_addr_i == `RV_RESET_PC)
        else begin
            fail_count++;
            $error("First fetch after reset is not at the reset PC");
        end

endmodule

/* verification/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_core_tb
    import rv_isa_pkg::*;
();

    localparam time    CLK_PERIOD = 100ns;
    localparam int     PROG_MAX   = 64;
    localparam instr_t SELF_LOOP  = 32'h0000_0063;  // BEQ x0,x0,0

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    instr_t      imem_data_i = '0;
    word_t       imem_addr_o;
    logic        wb_en_o;
    reg_addr_t   wb_rd_o;
    word_t       wb_data_o;
    instr_t      prog [PROG_MAX];
    int          prog_len;
    logic [31:0] lfsr_q = 32'ha6182cb9;
    reg_addr_t   exp_rd [$];
    word_t       exp_data [$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    rv_core rv_core_inst (.*);

    bind rv_core rv_core_assertions rv_core_assertions_inst (
        .clk         (clk),
        .rst         (rst),
        .imem_addr_i (imem_addr_o),
        .wb_en_i     (wb_en_o),
        .wb_rd_i     (wb_rd_o)
    );

    //////////////////////////////
    // Random source and encoders
    //////////////////////////////

    function automatic logic lfsr_step();
        logic b;
        b = lfsr_q[0];
        lfsr_q = (lfsr_q >> 1) ^ (b ? 32'hA300_0000 : 32'h0);
        return b;
    endfunction

    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
            v = (v << 1) | lfsr_step();
        return v;
    endfunction

    function automatic instr_t r_type(logic [6:0] f7, int rs2, int rs1, int f3, int rd);
        return {f7, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OPC_OP};
    endfunction

    function automatic instr_t i_type(int imm, int rs1, int f3, int rd, opcode_e opc);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), opc};
    endfunction

    function automatic instr_t s_type(int imm, int rs2, int rs1);
        logic [11:0] v;
        v = 12'(imm);
        return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], OPC_STORE};
    endfunction

    function automatic instr_t b_type(int imm, int rs2, int rs1, int f3);
        logic [12:0] v;
        v = 13'(imm);
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], OPC_BRANCH};
    endfunction

    function automatic void emit(instr_t ins);
        prog[prog_len] = ins;
        prog_len++;
    endfunction

    function automatic instr_t fetch_word(word_t addr);
        if ($isunknown(addr) || addr[31:2] >= prog_len)
            return '0;  // Past the end reads as a bubble
        return prog[addr[31:2]];
    endfunction

    //////////////////////////////
    // Program template
    //////////////////////////////

    task automatic build_program();
        int a, b, c, d, off;
        prog_len = 0;
        for (int r = 1; r <= 8; r++)
            emit(i_type(rand_bits(12), 0, F3_ADD_SUB, r, OPC_OP_IMM));
        a = rand_bits(3) + 1;
        b = rand_bits(3) + 1;
        // Each result feeds the next one or two instructions
        emit(r_type(7'h00, b, a, F3_ADD_SUB, 9));
        emit(r_type(7'h20, a, 9, F3_ADD_SUB, 10));
        emit(r_type(7'h00, 9, 10, F3_XOR, 11));
        emit(r_type(7'h00, 10, 11, F3_SLT, 12));
        emit(r_type(7'h00, 11, 9, F3_OR, 13));
        emit(r_type(7'h00, 13, b, F3_AND, 14));
        emit(i_type(rand_bits(12), 14, F3_ADD_SUB, 15, OPC_OP_IMM));
        emit(i_type(rand_bits(12), 15, F3_ADD_SUB, 0, OPC_OP_IMM));  // Dropped write
        emit(r_type(7'h00, 0, 15, F3_ADD_SUB, 16));
        off = rand_bits(6) * 4;
        c = rand_bits(3) + 1;
        emit(s_type(off, 16, 0));
        emit(i_type(off, 0, F3_WORD, 17, OPC_LOAD));
        emit(r_type(7'h00, 17, 17, F3_ADD_SUB, 18));   // Load-use
        emit(s_type(off + 4, 18, c));                    // Random base, wraps
        emit(i_type(off + 4, c, F3_WORD, 19, OPC_LOAD));
        emit(s_type(off + 8, 19, 0));                    // Loaded word as store data
        emit(i_type(off + 8, 0, F3_WORD, 20, OPC_LOAD));
        d = rand_bits(3) + 1;
        emit(b_type(12, d, d, F3_BEQ));                  // Taken
        emit(i_type(1, 0, F3_ADD_SUB, 21, OPC_OP_IMM));
        emit(i_type(2, 0, F3_ADD_SUB, 22, OPC_OP_IMM));
        emit(b_type(12, d, d, F3_BNE));                  // Not taken
        emit(i_type(3, 0, F3_ADD_SUB, 23, OPC_OP_IMM));
        emit(i_type(4, d, F3_ADD_SUB, 24, OPC_OP_IMM));
        emit(b_type(12, 24, d, F3_BNE));                 // Taken on a forwarded operand
        emit(i_type(5, 0, F3_ADD_SUB, 25, OPC_OP_IMM));
        emit(i_type(6, 0, F3_ADD_SUB, 26, OPC_OP_IMM));
        emit(i_type(off + 8, 0, F3_WORD, 27, OPC_LOAD));
        emit(b_type(12, 20, 27, F3_BEQ));                // Taken after a stall
        emit(i_type(7, 0, F3_ADD_SUB, 28, OPC_OP_IMM));
        emit(i_type(8, 0, F3_ADD_SUB, 29, OPC_OP_IMM));
        emit(b_type(8, 0, 24, F3_BEQ));
        emit(i_type(9, 24, F3_ADD_SUB, 30, OPC_OP_IMM));
        emit(SELF_LOOP);
    endtask

    // Instruction-set model, one instruction per step
    task automatic run_golden();
        word_t  regs [32];
        word_t  mem [`RV_DMEM_WORDS];
        word_t  pc, a, b, res;
        instr_t ins;
        logic   wr;
        int     steps;
        regs = '{default: '0};
        mem = '{default: '0};
        pc = `RV_RESET_PC;
        steps = 0;
        ins = prog[pc[31:2]];
        while (ins != SELF_LOOP && steps < 4 * PROG_MAX) begin
            a = regs[ins[19:15]];
            b = regs[ins[24:20]];
            res = a + {{20{ins[31]}}, ins[31:20]};  // ADDI sum or load address
            wr = 1'b1;
            case (ins[6:0])
                OPC_OP: begin
                    case (ins[14:12])
                        F3_ADD_SUB: res = ins[30] ? a - b : a + b;
                        F3_SLT:     res = word_t'($signed(a) < $signed(b));
                        F3_XOR:     res = a ^ b;
                        F3_OR:      res = a | b;
                        default:    res = a & b;
                    endcase
                end
                OPC_OP_IMM: wr = 1'b1;
                OPC_LOAD:   res = mem[(res >> 2) % `RV_DMEM_WORDS];
                OPC_STORE: begin
                    wr = 1'b0;
                    res = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    mem[(res >> 2) % `RV_DMEM_WORDS] = b;
                end
                OPC_BRANCH: begin
                    wr = 1'b0;
                    if ((a == b) == (ins[14:12] == F3_BEQ))
                        pc = pc - 4 + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 0) begin
                regs[ins[11:7]] = res;
                exp_rd.push_back(ins[11:7]);
                exp_data.push_back(res);
            end
            pc = pc + 4;
            steps++;
            ins = prog[pc[31:2]];
        end
    endtask

    //////////////////////////////
    // Checking
    //////////////////////////////

    task automatic halt_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped on the first error");
    endtask

    task automatic report_mismatch(string sig, word_t got, word_t exp);
        $display("MISMATCH at %0t: %s got %h, expected %h", $time, sig, got, exp);
        halt_run();
    endtask

    always @(posedge clk) begin
        #1;
        imem_data_i = fetch_word(imem_addr_o);  // Address is stable until the next edge
    end

    // Mid-cycle sample of the commit port
    always @(negedge clk) begin
        if (!rst && wb_en_o) begin
            if (exp_rd.size() == 0) begin
                $display("Unexpected write-back to x%0d at %0t", wb_rd_o, $time);
                halt_run();
            end else begin
                assert (wb_rd_o == exp_rd[0])
                    else report_mismatch("wb_rd_o", word_t'(wb_rd_o), word_t'(exp_rd[0]));
                assert (wb_data_o == exp_data[0])
                    else report_mismatch("wb_data_o", wb_data_o, exp_data[0]);
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    // Stop at the first failed port check
    always @(negedge clk) begin
        if (rv_core_inst.rv_core_assertions_inst.fail_count != 0) begin
            $display("A port assertion failed before %0t", $time);
            halt_run();
        end
    end

    initial begin
        build_program();
        run_golden();
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        while (exp_rd.size() != 0)
            @(posedge clk);
        repeat (10) @(negedge clk);  // Skipped instructions must stay off the port
        if (rv_core_inst.rv_core_assertions_inst.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("Port assertions failed during the run");
            halt_run();
        end
    end

    // Watchdog
    initial begin
        @(negedge rst);
        repeat (prog_len * 3 + 20) @(posedge clk);
        $display("Write-backs stopped with %0d results still expected", exp_rd.size());
        halt_run();
    end

endmodule
